/* src/rf_pkg.sv */
package rf_pkg;

    // One UART character
    typedef logic [7:0] data_t;

    // Mode pins as {M1, M0}
    typedef enum logic [1:0] {
        MODE_NORMAL     = 2'd0,
        MODE_WAKEUP     = 2'd1,
        MODE_POWER_SAVE = 2'd2,
        MODE_SLEEP      = 2'd3
    } op_mode_t;

    // Byte from a UART receiver, valid while strobe is high
    typedef struct packed {
        logic  strobe;
        data_t data;
    } uart_rx_t;

    // Byte for a UART transmitter, taken in the cycle start is high
    typedef struct packed {
        logic  start;
        data_t data;
    } uart_tx_t;

endpackage

/* src/byte_fifo.sv */
module byte_fifo #(
    parameter int DEPTH = 512
) (
    input  logic                           mode0_clk,
    input  logic                           rst_n,
    input  logic                           wr,
    input  rf_pkg::data_t                  wr_data,
    input  logic                           rd,
    output rf_pkg::data_t                  rd_data,
    output logic [$clog2(DEPTH + 1) - 1:0] count,
    output logic                           full,
    output logic                           empty
);
    import rf_pkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W - 1:0] ptr_t;
    typedef logic [CNT_W - 1:0] count_t;

    data_t mem [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    logic  do_wr;
    logic  do_rd;

    // Pointer advance with wrap for depths that are not a power of two
    function automatic ptr_t next_ptr(input ptr_t p);
        ptr_t n;
        if (p == ptr_t'(DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    // Full drops the write, empty ignores the read
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign full  = (count == count_t'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead head of the queue
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge mode0_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/quiet_timer.sv */
module quiet_timer #(
    parameter int LIMIT = 500000
) (
    input  logic mode0_clk,
    input  logic rst_n,
    input  logic run,
    input  logic clear,
    output logic expired
);

    localparam int CNT_W = $clog2(LIMIT + 1);

    typedef logic [CNT_W - 1:0] tick_t;

    tick_t ticks;

    // Counts uninterrupted running cycles and sticks at the limit
    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            ticks <= '0;
        end else if (!run || clear) begin
            ticks <= '0;
        end else if (ticks != tick_t'(LIMIT)) begin
            ticks <= ticks + 1'b1;
        end
    end

    // High from the LIMIT-th running cycle on
    assign expired = (ticks == tick_t'(LIMIT));

endmodule

/* src/uplink_ctrl.sv */
module uplink_ctrl #(
    parameter int FIFO_DEPTH     = 512,
    parameter int SEND_THRESHOLD = 58,
    parameter int GAP_CYCLES     = 500000
) (
    input  logic             mode0_clk,
    input  logic             rst_n,
    input  logic             normal_mode,
    input  rf_pkg::uart_rx_t mcu_rx,
    input  logic             node_tx_idle,
    output rf_pkg::uart_tx_t node_tx,
    output logic             idle
);
    import rf_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [CNT_W - 1:0] count_t;

    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        SEND
    } state_t;

    state_t state;
    state_t state_nxt;
    count_t fifo_count;
    data_t  fifo_head;
    logic   fifo_empty;
    logic   fifo_wr;
    logic   gap_expired;
    logic   send_start;
    logic   start_q;
    logic   frame_ready;

    // MCU bytes are only accepted in normal mode
    assign fifo_wr = mcu_rx.strobe && normal_mode;

    byte_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .mode0_clk(mode0_clk),
        .rst_n    (rst_n),
        .wr       (fifo_wr),
        .wr_data  (mcu_rx.data),
        .rd       (send_start),
        .rd_data  (fifo_head),
        .count    (fifo_count),
        .full     (),
        .empty    (fifo_empty)
    );

    // Gap detector restarts on every MCU byte
    quiet_timer #(
        .LIMIT(GAP_CYCLES)
    ) i_gap_timer (
        .mode0_clk(mode0_clk),
        .rst_n    (rst_n),
        .run      (state == COLLECT),
        .clear    (mcu_rx.strobe),
        .expired  (gap_expired)
    );

    // Enough for a frame, or the MCU went quiet
    assign frame_ready = (fifo_count >= count_t'(SEND_THRESHOLD)) || gap_expired;

    // One start per idle window of the node transmitter
    assign send_start = (state == SEND) && normal_mode && node_tx_idle
                        && !fifo_empty && !start_q;

    assign node_tx = '{start: send_start, data: fifo_head};
    assign idle    = (state == IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!fifo_empty) begin
                    state_nxt = COLLECT;
                end
            end
            COLLECT: begin
                if (frame_ready) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                if (fifo_empty) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= send_start;
            // Outside normal mode the FSM holds
            if (normal_mode) begin
                state <= state_nxt;
            end
        end
    end

endmodule

/* src/downlink_ctrl.sv */
module downlink_ctrl #(
    parameter int FIFO_DEPTH  = 512,
    parameter int HOLD_CYCLES = 20000
) (
    input  logic             mode0_clk,
    input  logic             rst_n,
    input  logic             normal_mode,
    input  rf_pkg::uart_rx_t node_rx,
    input  logic             mcu_tx_idle,
    output rf_pkg::uart_tx_t mcu_tx,
    output logic             idle
);
    import rf_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        HOLD,
        SEND
    } state_t;

    state_t state;
    state_t state_nxt;
    data_t  fifo_head;
    logic   fifo_empty;
    logic   hold_expired;
    logic   send_start;
    logic   start_q;
    logic   handed_off;

    // Over-the-air bytes are buffered in every mode
    byte_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .mode0_clk(mode0_clk),
        .rst_n    (rst_n),
        .wr       (node_rx.strobe),
        .wr_data  (node_rx.data),
        .rd       (send_start),
        .rd_data  (fifo_head),
        .count    (),
        .full     (),
        .empty    (fifo_empty)
    );

    // Hold time is measured from entry into HOLD
    quiet_timer #(
        .LIMIT(HOLD_CYCLES)
    ) i_hold_timer (
        .mode0_clk(mode0_clk),
        .rst_n    (rst_n),
        .run      (state == HOLD),
        .clear    (1'b0),
        .expired  (hold_expired)
    );

    assign send_start = (state == SEND) && normal_mode && mcu_tx_idle
                        && !fifo_empty && !start_q;

    // Last byte gone and the MCU transmitter back to idle
    assign handed_off = fifo_empty && mcu_tx_idle && !start_q;

    assign mcu_tx = '{start: send_start, data: fifo_head};
    assign idle   = (state == IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!fifo_empty) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (hold_expired) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                if (handed_off) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= send_start;
            if (normal_mode) begin
                state <= state_nxt;
            end
        end
    end

endmodule

/* src/rf_transceiver_top.sv */
module rf_transceiver_top #(
    parameter int FIFO_DEPTH     = 512,
    parameter int SEND_THRESHOLD = 58,
    parameter int GAP_CYCLES     = 500000,
    parameter int HOLD_CYCLES    = 20000
) (
    input  logic             mode0_clk,
    input  logic             rst_n,
    input  rf_pkg::op_mode_t mode,
    // MCU side UART
    input  rf_pkg::uart_rx_t mcu_rx,
    input  logic             mcu_tx_idle,
    output rf_pkg::uart_tx_t mcu_tx,
    // RF node side UART
    input  rf_pkg::uart_rx_t node_rx,
    input  logic             node_tx_idle,
    output rf_pkg::uart_tx_t node_tx,
    output logic             aux
);
    import rf_pkg::*;

    logic normal_mode;
    logic up_idle;
    logic dn_idle;

    // Data moves only with both mode pins low
    assign normal_mode = (mode == MODE_NORMAL);

    // MCU to RF node
    uplink_ctrl #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .SEND_THRESHOLD(SEND_THRESHOLD),
        .GAP_CYCLES    (GAP_CYCLES)
    ) i_uplink (
        .mode0_clk   (mode0_clk),
        .rst_n       (rst_n),
        .normal_mode (normal_mode),
        .mcu_rx      (mcu_rx),
        .node_tx_idle(node_tx_idle),
        .node_tx     (node_tx),
        .idle        (up_idle)
    );

    // RF node to MCU
    downlink_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .HOLD_CYCLES(HOLD_CYCLES)
    ) i_downlink (
        .mode0_clk  (mode0_clk),
        .rst_n      (rst_n),
        .normal_mode(normal_mode),
        .node_rx    (node_rx),
        .mcu_tx_idle(mcu_tx_idle),
        .mcu_tx     (mcu_tx),
        .idle       (dn_idle)
    );

    // AUX high only when neither path is busy
    assign aux = up_idle & dn_idle;

endmodule

/* verification/tb_rf_transceiver.sv */
module tb_rf_transceiver;
    timeunit 1ns;
    timeprecision 1ps;

    import rf_pkg::*;

    localparam int FIFO_DEPTH     = 64;
    localparam int SEND_THRESHOLD = 8;
    localparam int GAP_CYCLES     = 40;
    localparam int HOLD_CYCLES    = 30;

    logic     mode0_clk;
    logic     rst_n;
    op_mode_t mode;
    uart_rx_t mcu_rx;
    uart_rx_t node_rx;
    uart_tx_t mcu_tx;
    uart_tx_t node_tx;
    logic     mcu_tx_idle;
    logic     node_tx_idle;
    logic     aux;

    integer seed            = 32'h70d3003b;
    int     cycle           = 0;
    string  test_name       = "reset";
    int     value_errors    = 0;
    int     protocol_errors = 0;
    int     timeout_errors  = 0;

    // Reference model of the bytes in the order they entered each path
    data_t  up_exp[$];
    data_t  dn_exp[$];
    data_t  want;
    int     last_mcu_cycle  = 0;
    int     node_first      = -1;
    int     mcu_first       = -1;
    int     node_busy       = 0;
    int     mcu_busy        = 0;
    logic   node_start_q    = 1'b0;
    logic   mcu_start_q     = 1'b0;
    logic   node_idle_lag   = 1'b1;
    logic   mcu_idle_lag    = 1'b1;
    int     busy_age        = 0;

    rf_transceiver_top #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .SEND_THRESHOLD(SEND_THRESHOLD),
        .GAP_CYCLES    (GAP_CYCLES),
        .HOLD_CYCLES   (HOLD_CYCLES)
    ) i_dut (
        .mode0_clk   (mode0_clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .mcu_rx      (mcu_rx),
        .mcu_tx_idle (mcu_tx_idle),
        .mcu_tx      (mcu_tx),
        .node_rx     (node_rx),
        .node_tx_idle(node_tx_idle),
        .node_tx     (node_tx),
        .aux         (aux)
    );

    initial begin
        mode0_clk = 1'b0;
        forever #50 mode0_clk = ~mode0_clk;
    end

    always @(posedge mode0_clk) cycle <= cycle + 1;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Drive point 10 ns after the rising edge
    task automatic next_slot();
        @(posedge mode0_clk);
        #10;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            value_errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    // MCU bytes only count as traffic in normal mode
    task automatic send_mcu(input data_t b);
        mcu_rx = '{strobe: 1'b1, data: b};
        if (mode == MODE_NORMAL) begin
            up_exp.push_back(b);
        end
        last_mcu_cycle = cycle;
        next_slot();
        mcu_rx.strobe = 1'b0;
    endtask

    task automatic send_node(input data_t b);
        node_rx = '{strobe: 1'b1, data: b};
        dn_exp.push_back(b);
        next_slot();
        node_rx.strobe = 1'b0;
    endtask

    task automatic wait_delivered(input bit uplink, input int limit);
        int n;
        bit done;
        done = 1'b0;
        for (n = 0; n < limit && !done; n++) begin
            next_slot();
            done = uplink ? (up_exp.size() == 0) : (dn_exp.size() == 0);
        end
        assert (done) else begin
            timeout_errors++;
            $display("%s: %s bytes not delivered within %0d cycles", test_name,
                     uplink ? "uplink" : "downlink", limit);
        end
    endtask

    task automatic wait_aux_high(input int limit);
        int n;
        bit done;
        done = 1'b0;
        for (n = 0; n < limit && !done; n++) begin
            next_slot();
            done = aux;
        end
        assert (done) else begin
            timeout_errors++;
            $display("%s: aux did not return high within %0d cycles", test_name, limit);
        end
    endtask

    // Transmitter stubs and AUX checks sampled mid-cycle
    always begin
        @(negedge mode0_clk);
        if (rst_n) begin
            if (node_tx.start) begin
                assert (node_tx_idle) else begin
                    protocol_errors++;
                    $display("%s: node start while node_tx_idle was low", test_name);
                end
                assert (!node_start_q) else begin
                    protocol_errors++;
                    $display("%s: node starts in consecutive cycles", test_name);
                end
                assert (mode == MODE_NORMAL) else begin
                    protocol_errors++;
                    $display("%s: node start outside normal mode", test_name);
                end
                assert (up_exp.size() > 0) else begin
                    protocol_errors++;
                    $display("%s: node start with no uplink byte pending", test_name);
                end
                if (up_exp.size() > 0) begin
                    want = up_exp.pop_front();
                    check_value("node_tx.data", int'(want), int'(node_tx.data));
                end
                if (node_first < 0) node_first = cycle;
                node_busy = rand_range(1, 6);
            end
            if (mcu_tx.start) begin
                assert (mcu_tx_idle) else begin
                    protocol_errors++;
                    $display("%s: mcu start while mcu_tx_idle was low", test_name);
                end
                assert (!mcu_start_q) else begin
                    protocol_errors++;
                    $display("%s: mcu starts in consecutive cycles", test_name);
                end
                assert (mode == MODE_NORMAL) else begin
                    protocol_errors++;
                    $display("%s: mcu start outside normal mode", test_name);
                end
                assert (dn_exp.size() > 0) else begin
                    protocol_errors++;
                    $display("%s: mcu start with no downlink byte pending", test_name);
                end
                if (dn_exp.size() > 0) begin
                    want = dn_exp.pop_front();
                    check_value("mcu_tx.data", int'(want), int'(mcu_tx.data));
                end
                if (mcu_first < 0) mcu_first = cycle;
                mcu_busy = rand_range(1, 6);
            end
            // Bytes waiting in normal mode must pull aux low within two cycles
            if (mode == MODE_NORMAL && up_exp.size() + dn_exp.size() > 0) busy_age++;
            else busy_age = 0;
            if (busy_age > 2) begin
                assert (!aux) else begin
                    protocol_errors++;
                    $display("%s: aux high while bytes are pending", test_name);
                end
            end
            if (aux) begin
                assert (mcu_tx_idle) else begin
                    protocol_errors++;
                    $display("%s: aux high while the MCU transmitter is busy", test_name);
                end
            end
        end
        node_start_q = node_tx.start;
        mcu_start_q  = mcu_tx.start;
        @(posedge mode0_clk);
        #10;
        // Idle drops one cycle after the start, then stays low for the drawn count
        node_tx_idle  = node_idle_lag;
        node_idle_lag = (node_busy == 0);
        if (node_busy > 0) node_busy--;
        mcu_tx_idle  = mcu_idle_lag;
        mcu_idle_lag = (mcu_busy == 0);
        if (mcu_busy > 0) mcu_busy--;
    end

    initial begin
        int i;
        int n;
        int first_node_cycle;
        rst_n        = 1'b0;
        mode         = MODE_NORMAL;
        mcu_rx       = '0;
        node_rx      = '0;
        mcu_tx_idle  = 1'b1;
        node_tx_idle = 1'b1;
        repeat (16) @(posedge mode0_clk);
        #10;
        rst_n = 1'b1;

        @(negedge mode0_clk);
        check_value("aux", 1, int'(aux));
        check_value("node_tx.start", 0, int'(node_tx.start));
        check_value("mcu_tx.start", 0, int'(mcu_tx.start));
        next_slot();

        // A full frame goes out well before the gap timer could fire
        test_name  = "threshold_burst";
        node_first = -1;
        for (i = 0; i < SEND_THRESHOLD; i++) begin
            send_mcu(data_t'($random(seed)));
            if (i < SEND_THRESHOLD - 1) repeat (rand_range(0, 5)) next_slot();
        end
        wait_delivered(1'b1, 200);
        assert (node_first >= 0 && node_first - last_mcu_cycle < GAP_CYCLES) else begin
            value_errors++;
            $display("FAIL %s first start delay: expected < %0d, actual %0d", test_name,
                     GAP_CYCLES, node_first - last_mcu_cycle);
        end
        wait_aux_high(50);

        test_name  = "gap_flush";
        node_first = -1;
        n = rand_range(2, SEND_THRESHOLD - 1);
        for (i = 0; i < n; i++) begin
            send_mcu(data_t'($random(seed)));
            if (i < n - 1) repeat (rand_range(0, 5)) next_slot();
        end
        wait_delivered(1'b1, GAP_CYCLES + 100);
        assert (node_first - last_mcu_cycle >= GAP_CYCLES) else begin
            value_errors++;
            $display("FAIL %s first start delay: expected >= %0d, actual %0d", test_name,
                     GAP_CYCLES, node_first - last_mcu_cycle);
        end
        wait_aux_high(50);

        test_name        = "downlink_hold";
        mcu_first        = -1;
        first_node_cycle = cycle;
        n = rand_range(6, 12);
        for (i = 0; i < n; i++) begin
            send_node(data_t'($random(seed)));
            repeat (rand_range(0, 3)) next_slot();
        end
        wait_delivered(1'b0, HOLD_CYCLES + 300);
        assert (mcu_first - first_node_cycle >= HOLD_CYCLES) else begin
            value_errors++;
            $display("FAIL %s first start delay: expected >= %0d, actual %0d", test_name,
                     HOLD_CYCLES, mcu_first - first_node_cycle);
        end
        wait_aux_high(50);

        // Both paths loaded in the same cycles
        test_name = "aux";
        for (i = 0; i < 5; i++) begin
            mcu_rx = '{strobe: 1'b1, data: data_t'($random(seed))};
            up_exp.push_back(mcu_rx.data);
            send_node(data_t'($random(seed)));
            mcu_rx.strobe = 1'b0;
            repeat (rand_range(0, 3)) next_slot();
        end
        wait_delivered(1'b1, GAP_CYCLES + 100);
        wait_delivered(1'b0, HOLD_CYCLES + 300);
        wait_aux_high(20);

        test_name  = "sleep_mode";
        node_first = -1;
        mode       = MODE_SLEEP;
        next_slot();
        for (i = 0; i < 4; i++) begin
            send_mcu(data_t'($random(seed)));
            send_node(data_t'($random(seed)));
        end
        repeat (GAP_CYCLES + 10) next_slot();
        mode = MODE_NORMAL;
        wait_delivered(1'b0, HOLD_CYCLES + 300);
        wait_aux_high(50);
        repeat (GAP_CYCLES + 20) next_slot();
        assert (node_first < 0) else begin
            protocol_errors++;
            $display("%s: node start after leaving sleep with no MCU byte sent", test_name);
        end

        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
src/rf_pkg.sv
src/byte_fifo.sv
src/quiet_timer.sv
src/uplink_ctrl.sv
src/downlink_ctrl.sv
src/rf_transceiver_top.sv
verification/tb_rf_transceiver.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rf_transceiver
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
